// ==== periph_defs.svh ====
`ifndef PERIPH_DEFS_SVH
`define PERIPH_DEFS_SVH

// system clock in Hz for the 40 ns period
`define PERIPH_CLK_FREQ 32'd25000000

// width of the host byte address
`define PERIPH_ADDR_W 6

// address bit that picks the interrupt controller over the timer
`define PERIPH_SEL_BIT 5

// timer register byte offsets
`define TIM_PRE_OFS 5'h00
`define TIM_ARE_OFS 5'h04
`define TIM_CLR_OFS 5'h08
`define TIM_ENA_OFS 5'h0C
`define TIM_MOD_OFS 5'h10
`define TIM_CNT_OFS 5'h14
`define TIM_EVN_OFS 5'h18
`define TIM_EVC_OFS 5'h1C

// interrupt controller register byte offsets
`define IRQ_PEND_OFS 5'h00
`define IRQ_ENA_OFS  5'h04

`endif

// ==== periph_pkg.sv ====
package periph_pkg;

	// one register word, taken whole for arithmetic or lane by lane for
	// byte enabled writes and reads
	typedef union packed {
		logic [31:0]     word;
		logic [3:0][7:0] bytes;
	} periph_word_u;

	// interrupt sources
	// bit 0 is the timer event and bits 3..1 are the external events
	typedef logic [3:0] irq_src_t;

endpackage

// ==== periph_bus_if.sv ====
`timescale 1ns/1ps
`include "periph_defs.svh"

interface periph_bus_if;

	logic                      write;
	logic [3:0]                be;
	logic [`PERIPH_ADDR_W-2:0] addr; // offset inside a region, select bit stripped
	logic [31:0]               wdata;
	logic [31:0]               rdata; // combinational, same cycle as addr and be

	modport host (
		output write, be, addr, wdata,
		input  rdata
	);

	modport device (
		input  write, be, addr, wdata,
		output rdata
	);

endinterface

// ==== periph_bus_decoder.sv ====
`timescale 1ns/1ps
`include "periph_defs.svh"

module periph_bus_decoder (
	input  logic                      write_i,
	input  logic [3:0]                be_i,
	input  logic [`PERIPH_ADDR_W-1:0] addr_i,
	input  logic [31:0]               wdata_i,
	output logic [31:0]               rdata_o,
	periph_bus_if.host                tim_bus,
	periph_bus_if.host                irq_bus
);

	logic irq_sel;

	assign irq_sel = addr_i[`PERIPH_SEL_BIT];

	// ******************************************************************
	// request side
	// ******************************************************************

	// only the chosen region sees the strobe
	assign tim_bus.write = write_i && !irq_sel;
	assign irq_bus.write = write_i && irq_sel;

	// both regions get the same lanes and offset
	assign tim_bus.be    = be_i;
	assign tim_bus.addr  = addr_i[`PERIPH_SEL_BIT-1:0];
	assign tim_bus.wdata = wdata_i;

	assign irq_bus.be    = be_i;
	assign irq_bus.addr  = addr_i[`PERIPH_SEL_BIT-1:0];
	assign irq_bus.wdata = wdata_i;

	// ******************************************************************
	// response side
	// ******************************************************************

	assign rdata_o = irq_sel ? irq_bus.rdata : tim_bus.rdata;

endmodule

// ==== timer.sv ====
`timescale 1ns/1ps
`include "periph_defs.svh"

module timer (
	input  logic         clk_i,
	input  logic         rst_i,
	periph_bus_if.device bus,
	output logic         evt_o
);
	import periph_pkg::*;

	// configuration registers
	periph_word_u pre_q, pre_d;
	periph_word_u are_q, are_d;
	logic         clr_q, clr_d;
	logic         ena_q, ena_d;
	logic         mod_q, mod_d;
	logic         evc_q, evc_d;

	// status registers, read only from the bus
	periph_word_u cnt_q, cnt_d;
	periph_word_u evn_q, evn_d;

	// prescaler state
	logic [31:0] psc_q, psc_d;
	logic [31:0] tc_q, tc_d;

	logic       tick;
	logic       wrap;
	logic [5:0] lane_ofs [4];

	// byte lies inside the 32-bit word starting at base
	function automatic logic word_hit(input logic [5:0] ofs, input logic [4:0] base);
		return ofs[5:2] == {1'b0, base[4:2]};
	endfunction

	// byte is bit 0 of a single bit register
	function automatic logic bit_hit(input logic [5:0] ofs, input logic [4:0] base);
		return ofs == {1'b0, base};
	endfunction

	function automatic logic [7:0] rd_byte(input logic [5:0] ofs);
		logic [7:0] b;
		b = 8'h00; // unmapped and unaligned bytes
		if (word_hit(ofs, `TIM_PRE_OFS))
			b = pre_q.bytes[ofs[1:0]];
		else if (word_hit(ofs, `TIM_ARE_OFS))
			b = are_q.bytes[ofs[1:0]];
		else if (word_hit(ofs, `TIM_CNT_OFS))
			b = cnt_q.bytes[ofs[1:0]];
		else if (word_hit(ofs, `TIM_EVN_OFS))
			b = evn_q.bytes[ofs[1:0]];
		else if (bit_hit(ofs, `TIM_CLR_OFS))
			b = {7'b0, clr_q};
		else if (bit_hit(ofs, `TIM_ENA_OFS))
			b = {7'b0, ena_q};
		else if (bit_hit(ofs, `TIM_MOD_OFS))
			b = {7'b0, mod_q};
		else if (bit_hit(ofs, `TIM_EVC_OFS))
			b = {7'b0, evc_q};
		return b;
	endfunction

	// lane i of the bus word lands at addr+i, which may run past the region
	always_comb begin
		for (int i = 0; i < 4; i++)
			lane_ofs[i] = {1'b0, bus.addr} + 6'(i);
	end

	// ******************************************************************
	// register writes
	// ******************************************************************

	always_comb begin
		pre_d = pre_q;
		are_d = are_q;
		clr_d = clr_q;
		ena_d = ena_q;
		mod_d = mod_q;
		evc_d = evc_q;
		for (int i = 0; i < 4; i++) begin
			if (bus.write && bus.be[i]) begin
				if (word_hit(lane_ofs[i], `TIM_PRE_OFS))
					pre_d.bytes[lane_ofs[i][1:0]] = bus.wdata[8*i +: 8];
				else if (word_hit(lane_ofs[i], `TIM_ARE_OFS))
					are_d.bytes[lane_ofs[i][1:0]] = bus.wdata[8*i +: 8];
				else if (bit_hit(lane_ofs[i], `TIM_CLR_OFS))
					clr_d = bus.wdata[8*i];
				else if (bit_hit(lane_ofs[i], `TIM_ENA_OFS))
					ena_d = bus.wdata[8*i];
				else if (bit_hit(lane_ofs[i], `TIM_MOD_OFS))
					mod_d = bus.wdata[8*i];
				else if (bit_hit(lane_ofs[i], `TIM_EVC_OFS))
					evc_d = bus.wdata[8*i];
			end
		end
	end

	// ******************************************************************
	// prescaler and counters
	// ******************************************************************

	assign tick = ena_q && (psc_q == tc_q);
	assign wrap = tick && (cnt_q.word == are_q.word);

	always_comb begin
		psc_d = tick ? 32'd0 : psc_q + 32'd1;
		// all ones in PRE gives one tick per second
		tc_d  = (&pre_d.word) ? `PERIPH_CLK_FREQ - 32'd1 : pre_d.word;
		cnt_d = cnt_q;
		evn_d = evn_q;
		if (wrap) begin
			cnt_d.word = 32'd0;
			evn_d.word = evn_q.word + 32'd1;
		end else if (tick) begin
			cnt_d.word = mod_q ? cnt_q.word + 32'd1 : cnt_q.word - 32'd1;
		end
		if (clr_q)
			cnt_d.word = 32'd0; // held while the clear bit stays set
		if (evc_q)
			evn_d.word = 32'd0;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pre_q.word <= '1;
			are_q.word <= '1;
			clr_q      <= 1'b0;
			ena_q      <= 1'b1;
			mod_q      <= 1'b0; // count down
			evc_q      <= 1'b0;
			cnt_q.word <= 32'd0;
			evn_q.word <= 32'd0;
			psc_q      <= 32'd0;
			tc_q       <= `PERIPH_CLK_FREQ - 32'd1;
			evt_o      <= 1'b0;
		end else begin
			pre_q <= pre_d;
			are_q <= are_d;
			clr_q <= clr_d;
			ena_q <= ena_d;
			mod_q <= mod_d;
			evc_q <= evc_d;
			cnt_q <= cnt_d;
			evn_q <= evn_d;
			psc_q <= psc_d;
			tc_q  <= tc_d;
			evt_o <= wrap; // one cycle after the wrapping tick
		end
	end

	// ******************************************************************
	// read data
	// ******************************************************************

	always_comb begin
		bus.rdata = 32'd0;
		for (int i = 0; i < 4; i++) begin
			if (bus.be[i])
				bus.rdata[8*i +: 8] = rd_byte(lane_ofs[i]);
		end
	end

endmodule

// ==== irq_ctrl.sv ====
`timescale 1ns/1ps
`include "periph_defs.svh"

module irq_ctrl (
	input  logic                 clk_i,
	input  logic                 rst_i,
	periph_bus_if.device         bus,
	input  periph_pkg::irq_src_t src_i,
	output logic                 irq_o
);
	import periph_pkg::*;

	irq_src_t     pend_q, pend_d;
	irq_src_t     ena_q, ena_d;
	irq_src_t     pend_clr;
	periph_word_u pend_w;
	periph_word_u ena_w;
	logic [5:0]   lane_ofs [4];

	function automatic logic word_hit(input logic [5:0] ofs, input logic [4:0] base);
		return ofs[5:2] == {1'b0, base[4:2]};
	endfunction

	always_comb begin
		for (int i = 0; i < 4; i++)
			lane_ofs[i] = {1'b0, bus.addr} + 6'(i);
	end

	// ******************************************************************
	// pending and enable
	// ******************************************************************

	always_comb begin
		pend_clr = '0;
		ena_d    = ena_q;
		for (int i = 0; i < 4; i++) begin
			if (bus.write && bus.be[i]) begin
				// only byte 0 of each word holds bits
				if (lane_ofs[i] == {1'b0, `IRQ_PEND_OFS})
					pend_clr = bus.wdata[8*i +: 4];
				else if (lane_ofs[i] == {1'b0, `IRQ_ENA_OFS})
					ena_d = bus.wdata[8*i +: 4];
			end
		end
		pend_d = (pend_q & ~pend_clr) | src_i; // a pulse beats a clear in the same cycle
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pend_q <= '0;
			ena_q  <= '0;
			irq_o  <= 1'b0;
		end else begin
			pend_q <= pend_d;
			ena_q  <= ena_d;
			irq_o  <= |(pend_q & ena_q);
		end
	end

	// ******************************************************************
	// read data
	// ******************************************************************

	assign pend_w.word = {28'd0, pend_q};
	assign ena_w.word  = {28'd0, ena_q};

	always_comb begin
		bus.rdata = 32'd0;
		for (int i = 0; i < 4; i++) begin
			if (bus.be[i]) begin
				if (word_hit(lane_ofs[i], `IRQ_PEND_OFS))
					bus.rdata[8*i +: 8] = pend_w.bytes[lane_ofs[i][1:0]];
				else if (word_hit(lane_ofs[i], `IRQ_ENA_OFS))
					bus.rdata[8*i +: 8] = ena_w.bytes[lane_ofs[i][1:0]];
			end
		end
	end

endmodule

// ==== periph_top.sv ====
`timescale 1ns/1ps
`include "periph_defs.svh"

module periph_top (
	input  logic                      clk_i,
	input  logic                      rst_i,
	input  logic                      write_i,
	input  logic [3:0]                be_i,
	input  logic [`PERIPH_ADDR_W-1:0] addr_i,
	input  logic [31:0]               wdata_i,
	input  logic [2:0]                ext_evt_i,
	output logic [31:0]               rdata_o,
	output logic                      irq_o
);
	import periph_pkg::*;

	periph_bus_if tim_bus ();
	periph_bus_if irq_bus ();

	logic     tim_evt;
	irq_src_t irq_src;

	assign irq_src = {ext_evt_i, tim_evt}; // timer event sits in bit 0

	periph_bus_decoder decoder_i (
		.write_i (write_i),
		.be_i    (be_i),
		.addr_i  (addr_i),
		.wdata_i (wdata_i),
		.rdata_o (rdata_o),
		.tim_bus (tim_bus),
		.irq_bus (irq_bus)
	);

	timer timer_i (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.bus   (tim_bus),
		.evt_o (tim_evt)
	);

	irq_ctrl irq_ctrl_i (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.bus   (irq_bus),
		.src_i (irq_src),
		.irq_o (irq_o)
	);

endmodule

// ==== periph_tb.sv ====
`timescale 1ns/1ps
`include "periph_defs.svh"

module periph_tb;
	import periph_pkg::*;

	logic                      clk_i;
	logic                      rst_i;
	logic                      write_i;
	logic [3:0]                be_i;
	logic [`PERIPH_ADDR_W-1:0] addr_i;
	logic [31:0]               wdata_i;
	logic [2:0]                ext_evt_i;
	logic [31:0]               rdata_o;
	logic                      irq_o;

	int         errors;
	int         checks;
	int         cyc; // rising edges since reset was released
	logic       timed_out;
	logic [7:0] shadow [8]; // expected bytes of PRE (0..3) and ARE (4..7)

	periph_top periph_top_i (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.write_i   (write_i),
		.be_i      (be_i),
		.addr_i    (addr_i),
		.wdata_i   (wdata_i),
		.ext_evt_i (ext_evt_i),
		.rdata_o   (rdata_o),
		.irq_o     (irq_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		if (rst_i)
			cyc <= 0;
		else
			cyc <= cyc + 1;
	end

	// ******************************************************************
	// bus access and checks
	// ******************************************************************

	function automatic logic [`PERIPH_ADDR_W-1:0] reg_addr(input logic sel, input logic [4:0] ofs);
		logic [`PERIPH_ADDR_W-1:0] a;
		a = {1'b0, ofs};
		a[`PERIPH_SEL_BIT] = sel; // 1 picks the interrupt controller
		return a;
	endfunction

	// all tasks start and end on a falling edge
	task automatic apply_reset();
		rst_i = 1'b1;
		repeat (5) @(negedge clk_i);
		rst_i = 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge clk_i);
	endtask

	task automatic bus_write(input logic [`PERIPH_ADDR_W-1:0] addr, input logic [3:0] be,
			input logic [31:0] data);
		write_i = 1'b1;
		addr_i  = addr;
		be_i    = be;
		wdata_i = data;
		@(negedge clk_i);
		write_i = 1'b0;
	endtask

	task automatic bus_read(input logic [`PERIPH_ADDR_W-1:0] addr, input logic [3:0] be,
			output logic [31:0] data);
		addr_i = addr;
		be_i   = be;
		#5;
		data = rdata_o; // read data is combinational, settled well before the next edge
		@(negedge clk_i);
	endtask

	task automatic check_read(input logic [`PERIPH_ADDR_W-1:0] addr, input logic [3:0] be,
			input logic [31:0] exp, input string name);
		logic [31:0] got;
		bus_read(addr, be, got);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("ERROR %s rdata_o: got 0x%08h, expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic check_irq(input logic exp);
		checks++;
		assert (irq_o === exp)
		else begin
			errors++;
			$display("ERROR irq_o: got 0x%0h, expected 0x%0h", irq_o, exp);
		end
	endtask

	task automatic wait_irq(input logic level, input int max_cycles);
		int n;
		n = 0;
		while (irq_o !== level && n < max_cycles) begin
			@(negedge clk_i);
			n++;
		end
		if (irq_o !== level) begin
			errors++;
			timed_out = 1'b1;
			$display("timeout: irq_o did not reach %0b within %0d cycles", level, max_cycles);
		end
	endtask

	function automatic logic [31:0] shadow_read(input logic [2:0] a, input logic [3:0] be);
		logic [31:0] r;
		logic [2:0]  idx;
		r = 32'd0;
		for (int i = 0; i < 4; i++) begin
			idx = a + 3'(i);
			if (be[i])
				r[8*i +: 8] = shadow[idx];
		end
		return r;
	endfunction

	// with reload all ones a down count goes 0, all ones, wrap to 0 and so on
	function automatic logic [31:0] down_cnt(input int k);
		return k[0] ? 32'hFFFF_FFFF : 32'd0;
	endfunction

	// ******************************************************************
	// test sequences
	// ******************************************************************

	task automatic reset_values();
		int k;
		check_read(reg_addr(1'b0, `TIM_PRE_OFS), 4'hF, 32'hFFFF_FFFF, "PRE");
		check_read(reg_addr(1'b0, `TIM_ARE_OFS), 4'hF, 32'hFFFF_FFFF, "ARE");
		check_read(reg_addr(1'b0, `TIM_CLR_OFS), 4'hF, 32'd0, "CLR");
		check_read(reg_addr(1'b0, `TIM_ENA_OFS), 4'hF, 32'd1, "ENA");
		check_read(reg_addr(1'b0, `TIM_MOD_OFS), 4'hF, 32'd0, "MOD");
		check_read(reg_addr(1'b0, `TIM_EVC_OFS), 4'hF, 32'd0, "EVC");
		k = cyc / `PERIPH_CLK_FREQ; // one tick per second of clock cycles
		check_read(reg_addr(1'b0, `TIM_CNT_OFS), 4'hF, down_cnt(k), "CNT");
		check_read(reg_addr(1'b0, `TIM_EVN_OFS), 4'hF, k / 2, "EVN");
		check_read(reg_addr(1'b1, `IRQ_PEND_OFS), 4'hF, 32'd0, "PEND");
		check_read(reg_addr(1'b1, `IRQ_ENA_OFS), 4'hF, 32'd0, "IRQ_ENA");
		check_irq(1'b0);
	endtask

	task automatic byte_lanes();
		logic [2:0]  a;
		logic [3:0]  be;
		logic [31:0] d;
		logic [2:0]  idx;
		for (int i = 0; i < 8; i++)
			shadow[i] = 8'hFF;
		for (int n = 0; n < 16; n++) begin
			a  = 3'($urandom % 5);
			be = 4'($urandom);
			d  = $urandom;
			bus_write(reg_addr(1'b0, {2'b00, a}), be, d);
			for (int i = 0; i < 4; i++) begin
				idx = a + 3'(i); // lane i lands at addr+i
				if (be[i])
					shadow[idx] = d[8*i +: 8];
			end
			a  = 3'($urandom % 5);
			be = 4'($urandom);
			check_read(reg_addr(1'b0, {2'b00, a}), be, shadow_read(a, be), "PRE/ARE");
		end
		check_read(reg_addr(1'b0, `TIM_PRE_OFS), 4'hF, shadow_read(3'd0, 4'hF), "PRE");
		check_read(reg_addr(1'b0, `TIM_ARE_OFS), 4'hF, shadow_read(3'd4, 4'hF), "ARE");
		// upper bytes of CLR read zero, lane 3 reaches bit 0 of ENA
		check_read(reg_addr(1'b0, 5'h09), 4'hF, 32'h0100_0000, "CLR+1");
		check_read(reg_addr(1'b0, 5'h1D), 4'hF, 32'd0, "EVC+1");
		check_read(reg_addr(1'b1, 5'h08), 4'hF, 32'd0, "IRQ unmapped");
		bus_write(reg_addr(1'b1, 5'h10), 4'hF, 32'hFFFF_FFFF);
		check_read(reg_addr(1'b1, `IRQ_ENA_OFS), 4'hF, 32'd0, "IRQ_ENA");
	endtask

	task automatic count_up();
		int k;
		apply_reset();
		// PRE goes first so the terminal count is set before the prescaler reaches it
		bus_write(reg_addr(1'b0, `TIM_PRE_OFS), 4'hF, 32'd3);
		bus_write(reg_addr(1'b0, `TIM_MOD_OFS), 4'h1, 32'd1);
		bus_write(reg_addr(1'b0, `TIM_ARE_OFS), 4'hF, 32'd5);
		repeat (2) begin
			idle(37);
			k = cyc / 4; // tick every 4 cycles, wrap after 6 ticks
			check_read(reg_addr(1'b0, `TIM_CNT_OFS), 4'hF, k % 6, "CNT");
			k = cyc / 4;
			check_read(reg_addr(1'b0, `TIM_EVN_OFS), 4'hF, k / 6, "EVN");
		end
	endtask

	task automatic count_down_and_clear();
		int k;
		int rel;
		apply_reset();
		bus_write(reg_addr(1'b0, `TIM_PRE_OFS), 4'hF, 32'd1); // tick every other cycle
		repeat (4) begin
			k = cyc / 2;
			check_read(reg_addr(1'b0, `TIM_CNT_OFS), 4'hF, down_cnt(k), "CNT");
			k = cyc / 2;
			check_read(reg_addr(1'b0, `TIM_EVN_OFS), 4'hF, k / 2, "EVN");
		end
		bus_write(reg_addr(1'b0, `TIM_EVC_OFS), 4'h1, 32'd1);
		idle(2);
		check_read(reg_addr(1'b0, `TIM_EVN_OFS), 4'hF, 32'd0, "EVN");
		k = cyc / 2; // the count keeps running while EVN is held
		check_read(reg_addr(1'b0, `TIM_CNT_OFS), 4'hF, down_cnt(k), "CNT");
		check_read(reg_addr(1'b0, `TIM_EVN_OFS), 4'hF, 32'd0, "EVN");
		bus_write(reg_addr(1'b0, `TIM_CLR_OFS), 4'h1, 32'd1);
		idle(3);
		check_read(reg_addr(1'b0, `TIM_CNT_OFS), 4'hF, 32'd0, "CNT");
		idle(2);
		check_read(reg_addr(1'b0, `TIM_CNT_OFS), 4'hF, 32'd0, "CNT");
		bus_write(reg_addr(1'b0, `TIM_EVC_OFS), 4'h1, 32'd0);
		rel = cyc;
		bus_write(reg_addr(1'b0, `TIM_CLR_OFS), 4'h1, 32'd0);
		repeat (3) begin
			idle(1);
			k = cyc / 2 - (rel + 1) / 2; // ticks since CLR dropped
			check_read(reg_addr(1'b0, `TIM_CNT_OFS), 4'hF, down_cnt(k), "CNT");
			k = cyc / 2 - (rel + 1) / 2;
			check_read(reg_addr(1'b0, `TIM_EVN_OFS), 4'hF, k / 2, "EVN");
		end
	endtask

	task automatic interrupts();
		irq_src_t exp_pend;
		apply_reset();
		bus_write(reg_addr(1'b0, `TIM_PRE_OFS), 4'hF, 32'd1);
		bus_write(reg_addr(1'b0, `TIM_MOD_OFS), 4'h1, 32'd1); // one wrap, then counting up
		bus_write(reg_addr(1'b1, `IRQ_ENA_OFS), 4'h1, 32'd1);
		wait_irq(1'b1, 20);
		if (timed_out)
			return;
		exp_pend = 4'b0001;
		check_read(reg_addr(1'b1, `IRQ_PEND_OFS), 4'hF, {28'd0, exp_pend}, "PEND");
		bus_write(reg_addr(1'b1, `IRQ_PEND_OFS), 4'h1, 32'd1);
		check_read(reg_addr(1'b1, `IRQ_PEND_OFS), 4'hF, 32'd0, "PEND");
		wait_irq(1'b0, 4);
		if (timed_out)
			return;
		ext_evt_i = 3'b001; // masked source 1
		idle(1);
		ext_evt_i = 3'b000;
		exp_pend  = 4'b0010;
		check_read(reg_addr(1'b1, `IRQ_PEND_OFS), 4'hF, {28'd0, exp_pend}, "PEND");
		repeat (3) begin
			check_irq(1'b0);
			idle(1);
		end
		// a pulse on source 2 beats the clear written in the same cycle
		ext_evt_i = 3'b010;
		bus_write(reg_addr(1'b1, `IRQ_PEND_OFS), 4'h1, 32'h0000_000E);
		ext_evt_i = 3'b000;
		exp_pend  = 4'b0100;
		check_read(reg_addr(1'b1, `IRQ_PEND_OFS), 4'hF, {28'd0, exp_pend}, "PEND");
		bus_write(reg_addr(1'b1, `IRQ_PEND_OFS), 4'hF, 32'h0000_000F);
		check_read(reg_addr(1'b1, `IRQ_PEND_OFS), 4'hF, 32'd0, "PEND");
		check_irq(1'b0);
	endtask

	initial begin
		errors    = 0;
		checks    = 0;
		timed_out = 1'b0;
		rst_i     = 1'b1;
		write_i   = 1'b0;
		be_i      = 4'h0;
		addr_i    = '0;
		wdata_i   = 32'd0;
		ext_evt_i = 3'b000;
		void'($urandom(32'h441e_8b75));
		apply_reset();
		reset_values();
		byte_lanes();
		count_up();
		count_down_and_clear();
		interrupts();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+.
periph_pkg.sv
periph_bus_if.sv
periph_bus_decoder.sv
timer.sv
irq_ctrl.sv
periph_top.sv
periph_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := periph_tb
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Result: PASSED
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
